// File: common/cpu_wait_params.svh
////////////////////////////////////////
// cpu wait subsystem parameters
// widths and counts shared by the RTL
////////////////////////////////////////
`ifndef CPU_WAIT_PARAMS_SVH
`define CPU_WAIT_PARAMS_SVH

// missed-cycle counter, saturates at all ones
`define CPU_WAIT_MISS_W 4
// shared-device busy inputs
`define CPU_WAIT_DEVCNT 2
// ROM address and data widths
`define CPU_WAIT_AW 16
`define CPU_WAIT_DW 8
// numerator and denominator of the fractional divider
`define CPU_WAIT_FRAC_W 10

`endif

// File: common/wait_pkg.sv
////////////////////////////////////////
// wait decision types
// stall reasons and the miss counter word
////////////////////////////////////////
`include "cpu_wait_params.svh"

package wait_pkg;

    // reason the current CPU cycle is gated
    // priority order is dev_busy, rom_start, rom_miss
    typedef enum logic [1:0] {
        cause_none      = 2'd0,
        cause_rom_start = 2'd1,
        cause_rom_miss  = 2'd2,
        cause_dev_busy  = 2'd3
    } stall_cause_t;

    // lost ROM cycles waiting to be replayed
    typedef logic [`CPU_WAIT_MISS_W-1:0] miss_cnt_t;

endpackage

// File: common/rom_pkg.sv
////////////////////////////////////////
// SDRAM ROM port types
// FSM states and the address/data words
////////////////////////////////////////
`include "cpu_wait_params.svh"

package rom_pkg;

    // refill FSM of the ROM port
    typedef enum logic [1:0] {
        rom_idle     = 2'd0,
        rom_request  = 2'd1,
        rom_wait_ack = 2'd2,
        rom_valid    = 2'd3
    } rom_state_t;

    typedef logic [`CPU_WAIT_AW-1:0] rom_addr_t;
    typedef logic [`CPU_WAIT_DW-1:0] rom_data_t;

endpackage

// File: source/cen_frac.sv
////////////////////////////////////////
// fractional clock enable
// num pulses every den clocks on average
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

module cen_frac (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CPU_WAIT_FRAC_W-1:0] num,
    input  logic [`CPU_WAIT_FRAC_W-1:0] den,
    output logic                        cen
);

    // one extra bit so acc + num never overflows
    logic [`CPU_WAIT_FRAC_W:0] acc;
    logic [`CPU_WAIT_FRAC_W:0] sum;
    logic [`CPU_WAIT_FRAC_W:0] den_ext;
    logic                      wrap;

    ////////////////////////////////////////
    // modular accumulator

    assign den_ext = {1'b0, den};
    assign sum     = acc + {1'b0, num};
    // accumulator wraps once the sum reaches den
    assign wrap    = (sum >= den_ext);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else begin
            // one clk pulse per wrap
            // with num <= den/2 two wraps are never adjacent
            cen <= wrap;
            if (wrap) begin
                acc <= sum - den_ext;
            end else begin
                acc <= sum;
            end
        end
    end

endmodule

// File: bus_wait/bus_wait.sv
////////////////////////////////////////
// CPU bus wait unit
// gates clock enables on ROM or device
// stalls and replays lost ROM cycles
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

module bus_wait (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen_in,
    input  logic                        rom_cs,
    input  logic                        rom_ok,
    input  logic [`CPU_WAIT_DEVCNT-1:0] dev_busy,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        busak_n,
    output logic                        cen_out,
    output logic                        gate,
    output wait_pkg::stall_cause_t      stall_cause,
    output wait_pkg::miss_cnt_t         miss_cnt
);
    import wait_pkg::*;

    logic         last_rom_cs;
    logic         rom_cs_rise;
    logic         rom_wait;
    logic         rom_bad;
    logic         dev_any;
    logic         stall_now;
    logic         locked;
    logic         started;
    logic         rec_en;
    logic         rec;
    logic         cen_l;
    stall_cause_t live_cause;
    stall_cause_t held_cause;

    ////////////////////////////////////////
    // stall detection

    assign rom_cs_rise = rom_cs && !last_rom_cs;
    // selected ROM whose data has not arrived yet
    assign rom_wait    = rom_cs && !rom_ok;
    // first cycle of a select is always stalled, data may be stale
    assign rom_bad     = rom_wait || rom_cs_rise;
    assign dev_any     = |dev_busy;
    assign stall_now   = rom_bad || dev_any;

    // locked keeps every stall at least 2 cycles long
    assign gate = !(stall_now || locked);

    // highest priority cause first
    always_comb begin
        if (dev_any) begin
            live_cause = cause_dev_busy;
        end else if (rom_cs_rise) begin
            live_cause = cause_rom_start;
        end else if (rom_wait) begin
            live_cause = cause_rom_miss;
        end else begin
            live_cause = cause_none;
        end
    end

    // the locked tail reports what caused the stall
    assign stall_cause = (live_cause != cause_none) ? live_cause :
                         (locked ? held_cause : cause_none);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // reset high so rom_cs held out of reset is no edge
            last_rom_cs <= 1'b1;
            locked      <= 1'b0;
            started     <= 1'b0;
            held_cause  <= cause_none;
        end else begin
            last_rom_cs <= rom_cs;
            locked      <= stall_now;
            if (stall_now) begin
                held_cause <= live_cause;
            end else begin
                // first free cycle arms the miss counter
                started <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // cycle recovery

    // bus idle, nobody using memory or IO
    assign rec_en = mreq_n && iorq_n && busak_n;
    // never next to another enable pulse
    assign rec    = (miss_cnt != '0) && !cen_in && rec_en && !cen_l;

    assign cen_out = (cen_in && gate) || rec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_l    <= 1'b0;
            miss_cnt <= '0;
        end else begin
            cen_l <= cen_out;
            if (!started) begin
                miss_cnt <= '0;
            end else if (cen_in && !gate && !dev_any) begin
                // ROM stall ate a pulse, busy device losses are dropped
                if (miss_cnt != '1) begin
                    miss_cnt <= miss_cnt + 1'b1;
                end
            end else if (rec) begin
                miss_cnt <= miss_cnt - 1'b1;
            end
        end
    end

endmodule

// File: rom_port/rom_port.sv
////////////////////////////////////////
// SDRAM ROM port
// turns CPU ROM selects into SDRAM
// reads and holds the returned byte
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

module rom_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rom_cs,
    input  logic [`CPU_WAIT_AW-1:0] rom_addr,
    output logic                  rom_ok,
    output rom_pkg::rom_data_t    rom_data,
    output logic                  sdram_req,
    output rom_pkg::rom_addr_t    sdram_addr,
    input  logic                  sdram_ack,
    input  logic [`CPU_WAIT_DW-1:0] sdram_data
);
    import rom_pkg::*;

    rom_state_t state;
    logic       addr_hit;
    logic       miss;

    // sdram_addr doubles as the last latched address
    assign addr_hit = (rom_addr == sdram_addr);
    // nothing valid yet, or a new address is selected
    assign miss     = rom_cs && ((state == rom_idle) ||
                                 ((state == rom_valid) && !addr_hit));

    ////////////////////////////////////////
    // handshake outputs

    // level request held until the ack strobe
    assign sdram_req = (state == rom_request) || (state == rom_wait_ack);
    // drops at once when the CPU moves to another address
    assign rom_ok    = (state == rom_valid) && addr_hit;

    ////////////////////////////////////////
    // refill FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rom_idle;
        end else begin
            case (state)
                rom_idle, rom_valid: begin
                    if (miss) begin
                        state <= rom_request;
                    end
                end
                rom_request, rom_wait_ack: begin
                    // ack may come on the first request cycle
                    if (sdram_ack) begin
                        state <= rom_valid;
                    end else begin
                        state <= rom_wait_ack;
                    end
                end
                default: state <= rom_idle;
            endcase
        end
    end

    // address and data words
    always_ff @(posedge clk) begin
        if (miss) begin
            sdram_addr <= rom_addr;
        end
        if (sdram_req && sdram_ack) begin
            rom_data <= sdram_data;
        end
    end

endmodule

// File: source/cpu_wait_top.sv
////////////////////////////////////////
// CPU clock enable subsystem
// fractional enable, wait unit, ROM port
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

module cpu_wait_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CPU_WAIT_FRAC_W-1:0] num,
    input  logic [`CPU_WAIT_FRAC_W-1:0] den,
    input  logic                        rom_cs,
    input  logic [`CPU_WAIT_AW-1:0]     rom_addr,
    input  logic [`CPU_WAIT_DEVCNT-1:0] dev_busy,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        busak_n,
    output logic                        cen_out,
    output logic                        gate,
    output wait_pkg::stall_cause_t      stall_cause,
    output logic [`CPU_WAIT_MISS_W-1:0] miss_cnt,
    output logic [`CPU_WAIT_DW-1:0]     rom_data,
    output logic                        sdram_req,
    output logic [`CPU_WAIT_AW-1:0]     sdram_addr,
    input  logic                        sdram_ack,
    input  logic [`CPU_WAIT_DW-1:0]     sdram_data
);

    // nominal enable before gating
    logic cen_in;
    // ROM byte ready for the current address
    logic rom_ok;

    cen_frac u_cen (
        .clk         (clk),
        .rst_n       (rst_n),
        .num         (num),
        .den         (den),
        .cen         (cen_in)
    );

    bus_wait u_wait (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen_in      (cen_in),
        .rom_cs      (rom_cs),
        .rom_ok      (rom_ok),
        .dev_busy    (dev_busy),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .busak_n     (busak_n),
        .cen_out     (cen_out),
        .gate        (gate),
        .stall_cause (stall_cause),
        .miss_cnt    (miss_cnt)
    );

    rom_port u_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_ok      (rom_ok),
        .rom_data    (rom_data),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .sdram_data  (sdram_data)
    );

endmodule

// File: verification/cpu_wait_checker.sv
////////////////////////////////////////
// wait unit checker
// concurrent assertions bound into bus_wait
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

module cpu_wait_checker (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        cen_in,
    input logic                        cen_out,
    input logic                        gate,
    input logic                        rom_cs,
    input logic [`CPU_WAIT_MISS_W-1:0] miss_cnt,
    input wait_pkg::stall_cause_t      stall_cause
);
    import wait_pkg::*;

    // CPU enables must stay isolated pulses
    no_adjacent_cen: assert property (@(posedge clk) disable iff (!rst_n)
        cen_out |=> !cen_out)
        else $error("cen_out high in two consecutive clocks");

    // an enable without cen_in is a replayed cycle
    // it needs a lost one behind it and uses that one up
    rec_uses_miss: assert property (@(posedge clk) disable iff (!rst_n)
        (cen_out && !cen_in) |=>
            (($past(miss_cnt) != '0) && (miss_cnt == $past(miss_cnt) - 1'b1)))
        else $error("recovery pulse without a counted miss");

    // a new select is always held off since its data may be stale
    gate_on_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rom_cs) |-> (!gate && ((stall_cause == cause_rom_start) ||
                                     (stall_cause == cause_dev_busy))))
        else $error("gate open or wrong cause in the cycle rom_cs rose");

endmodule

// File: verification/cpu_wait_tb.sv
////////////////////////////////////////
// cpu wait subsystem testbench
// SDRAM model, golden stimulus, watchdog
////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_wait_params.svh"

bind bus_wait cpu_wait_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cen_in      (cen_in),
    .cen_out     (cen_out),
    .gate        (gate),
    .rom_cs      (rom_cs),
    .miss_cnt    (miss_cnt),
    .stall_cause (stall_cause)
);

module cpu_wait_tb;
    import wait_pkg::*;

    // first ROM select cycle and the gap before the address change
    localparam int ROM_START  = 20;
    localparam int READDR_GAP = 40;
    localparam int MAX_TESTS  = 16;

    logic                        clk;
    logic                        rst_n;
    logic [`CPU_WAIT_FRAC_W-1:0] num;
    logic [`CPU_WAIT_FRAC_W-1:0] den;
    logic                        rom_cs;
    logic [`CPU_WAIT_AW-1:0]     rom_addr;
    logic [`CPU_WAIT_DEVCNT-1:0] dev_busy;
    logic                        mreq_n;
    logic                        iorq_n;
    logic                        busak_n;
    logic                        sdram_ack;
    logic [`CPU_WAIT_DW-1:0]     sdram_data;
    logic                        cen_out;
    logic                        gate;
    stall_cause_t                stall_cause;
    logic [`CPU_WAIT_MISS_W-1:0] miss_cnt;
    logic [`CPU_WAIT_DW-1:0]     rom_data;
    logic                        sdram_req;
    logic [`CPU_WAIT_AW-1:0]     sdram_addr;

    // golden columns
    int t_num[MAX_TESTS];
    int t_den[MAX_TESTS];
    int t_lat[MAX_TESTS];
    int t_busy[MAX_TESTS];
    int t_rec[MAX_TESTS];
    int t_win[MAX_TESTS];
    int t_out[MAX_TESTS];
    int t_in[MAX_TESTS];
    int n_tests;
    int total_cycles;
    int errors;
    int checks;
    int seed;
    int req_cnt;
    int lat_now;
    bit loaded;

    cpu_wait_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .num         (num),
        .den         (den),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .dev_busy    (dev_busy),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .busak_n     (busak_n),
        .cen_out     (cen_out),
        .gate        (gate),
        .stall_cause (stall_cause),
        .miss_cnt    (miss_cnt),
        .rom_data    (rom_data),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .sdram_data  (sdram_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ROM contents mix every address bit
    function automatic logic [7:0] rom_pattern(input logic [15:0] addr);
        return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'hc3;
    endfunction

    ////////////////////////////////////////
    // SDRAM model

    // one cycle ack strobe after lat_now cycles of request
    always @(posedge clk) begin
        #1;
        sdram_ack = 1'b0;
        if (sdram_req) begin
            req_cnt = req_cnt + 1;
            if (req_cnt >= lat_now) begin
                sdram_ack  = 1'b1;
                sdram_data = rom_pattern(sdram_addr);
                req_cnt    = 0;
            end
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks = checks + 1;
        assert (got == exp)
        else begin
            $display("Fail %s: got %0h expected %0h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    code;
        string line;
        int    v[8];
        fd = $fopen("verification/cpu_wait_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file could not be opened");
            errors = errors + 1;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                // skip comment and blank lines
                if (code > 0 && line.len() > 0 && line[0] != 8'h23) begin
                    code = $sscanf(line, "%d %d %d %d %d %d %d %d",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (code == 8) begin
                        t_num[n_tests]  = v[0];
                        t_den[n_tests]  = v[1];
                        t_lat[n_tests]  = v[2];
                        t_busy[n_tests] = v[3];
                        t_rec[n_tests]  = v[4];
                        t_win[n_tests]  = v[5];
                        t_out[n_tests]  = v[6];
                        t_in[n_tests]   = v[7];
                        total_cycles    = total_cycles + v[5];
                        n_tests         = n_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // one golden line

    task automatic run_test(input int t);
        int               i;
        int               in_cnt;
        int               out_cnt;
        int               exp_miss;
        int               r2;
        int               err_before;
        logic [15:0]      addr_a;
        logic [15:0]      addr_b;
        err_before = errors;
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        num      = t_num[t][`CPU_WAIT_FRAC_W-1:0];
        den      = t_den[t][`CPU_WAIT_FRAC_W-1:0];
        lat_now  = t_lat[t];
        rom_cs   = 1'b0;
        rom_addr = '0;
        dev_busy = '0;
        // mreq_n low keeps the bus busy and blocks recovery
        mreq_n   = (t_rec[t] != 0);
        iorq_n   = 1'b1;
        busak_n  = 1'b1;
        repeat (15) @(posedge clk);
        @(negedge clk);
        req_cnt = 0;
        assert (!cen_out && !sdram_req && !DUT.u_rom.rom_ok && stall_cause == cause_none)
        else begin
            $display("outputs not idle while reset is asserted");
            errors = errors + 1;
        end
        checks = checks + 1;
        @(posedge clk);
        #1;
        rst_n  = 1'b1;
        addr_a = 16'($random(seed));
        addr_b = 16'($random(seed));
        while (addr_b == addr_a) begin
            addr_b = 16'($random(seed));
        end
        r2      = ROM_START + t_lat[t] + READDR_GAP;
        in_cnt  = 0;
        out_cnt = 0;
        for (i = 1; i <= t_win[t]; i++) begin
            @(posedge clk);
            #1;
            if (t_lat[t] > 0 && i == ROM_START) begin
                rom_cs   = 1'b1;
                rom_addr = addr_a;
            end
            if (t_lat[t] > 0 && i == r2) begin
                rom_addr = addr_b;
            end
            if (t_busy[t] > 0) begin
                dev_busy = (i >= ROM_START && i < ROM_START + t_busy[t]) ? 2'b10 : 2'b00;
            end
            @(negedge clk);
            if (DUT.u_wait.cen_in) in_cnt = in_cnt + 1;
            if (cen_out) out_cnt = out_cnt + 1;
            if (DUT.u_rom.rom_ok) begin
                check_value("rom_data", int'(rom_data), int'(rom_pattern(rom_addr)));
            end
            // refill request carries the selected address
            if (sdram_req) begin
                check_value("sdram_addr", int'(sdram_addr), int'(rom_addr));
            end
            // busy device outranks any ROM reason
            if (dev_busy != '0) begin
                check_value("gate", int'(gate), 0);
                check_value("stall_cause", int'(stall_cause), int'(cause_dev_busy));
            end else if (t_lat[t] > 0 && i == ROM_START) begin
                check_value("gate", int'(gate), 0);
                check_value("stall_cause", int'(stall_cause), int'(cause_rom_start));
            end else if (t_lat[t] > 0 && i == r2) begin
                check_value("gate", int'(gate), 0);
                check_value("stall_cause", int'(stall_cause), int'(cause_rom_miss));
            end
        end
        // without recovery every ROM loss stays in the counter
        if (t_rec[t] == 0 && t_busy[t] == 0) begin
            exp_miss = t_in[t] - t_out[t];
            if (exp_miss > 15) exp_miss = 15;
        end else begin
            exp_miss = 0;
        end
        check_value("cen_in count", in_cnt, t_in[t]);
        check_value("cen_out count", out_cnt, t_out[t]);
        check_value("miss_cnt", int'(miss_cnt), exp_miss);
        $display("test %0d num %0d den %0d latency %0d busy %0d recovery %0d: %s",
                 t, t_num[t], t_den[t], t_lat[t], t_busy[t], t_rec[t],
                 (errors == err_before) ? "ok" : "FAILED");
    endtask

    // watchdog sized from the golden windows
    initial begin
        wait (loaded);
        #(total_cycles * 4 * 2);
        $display("watchdog expired, simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        num          = 10'd1;
        den          = 10'd4;
        rom_cs       = 1'b0;
        rom_addr     = '0;
        dev_busy     = '0;
        mreq_n       = 1'b1;
        iorq_n       = 1'b1;
        busak_n      = 1'b1;
        sdram_ack    = 1'b0;
        sdram_data   = '0;
        seed         = 91972;
        errors       = 0;
        checks       = 0;
        n_tests      = 0;
        total_cycles = 0;
        req_cnt      = 0;
        lat_now      = 1;
        loaded       = 1'b0;
        load_golden();
        loaded = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests run %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verification/cpu_wait_golden.txt
# columns: num den sdram_latency busy_cycles recovery window cen_out_count cen_in_count
# latency 0 means no ROM select, busy 0 means no busy device
#
# ROM idle, plain division
1 4 0 0 1 200 50 50
3 10 0 0 1 200 60 60
#
# ROM misses with idle bus, lost pulses replayed
1 4 5 0 1 200 50 50
#
# long misses with mreq_n low, counter saturates
1 4 70 0 0 200 14 50
#
# busy device for 30 cycles, losses dropped
1 4 0 30 1 200 42 50
#
# short misses, rom_data checked on both addresses
1 4 3 0 1 200 50 50

// File: cpu_wait.f
+incdir+common
common/wait_pkg.sv
common/rom_pkg.sv
source/cen_frac.sv
bus_wait/bus_wait.sv
rom_port/rom_port.sv
source/cpu_wait_top.sv
verification/cpu_wait_checker.sv
verification/cpu_wait_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the cpu wait testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_wait_tb -f cpu_wait.f -o sim_cpu_wait
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_cpu_wait > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
